/* hw/xgmii_tx_pkg.sv */
// xgmii transmit package with lane constants, control characters and frame helpers
package xgmii_tx_pkg;

    localparam int DATA_W = 64;
    localparam int LANES = 8;
    localparam int EMPTY_W = 3;

    localparam logic [7:0] ETH_PRE = 8'h55;
    localparam logic [7:0] ETH_SFD = 8'hD5;

    localparam logic [7:0] XGMII_IDLE = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hFB;
    localparam logic [7:0] XGMII_TERM = 8'hFD;
    localparam logic [7:0] XGMII_ERROR = 8'hFE;

    localparam logic [7:0] MIN_IFG_BYTES = 8'd12;
    localparam logic [31:0] CRC_POLY = 32'h04C11DB7;

    typedef enum logic [2:0] {
        IDLE,
        PAYLOAD,
        PAD,
        FCS_1,
        FCS_2,
        ERR,
        IFG
    } tx_state_e;

    // count of unused high lanes, lane 0 always counts as used
    function automatic logic [EMPTY_W-1:0] keep_to_empty(input logic [LANES-1:0] keep);
        logic run;
        logic [EMPTY_W-1:0] empty;
        run = keep[0];
        empty = EMPTY_W'(LANES - 1);
        for (int i = 1; i < LANES; i++) begin
            run = run & keep[i];
            if (run) begin
                empty = EMPTY_W'(LANES - 1 - i);
            end
        end
        return empty;
    endfunction

    // idle bytes that follow the terminate character in its own word
    function automatic logic [7:0] term_ifg_offset(input logic [EMPTY_W-1:0] empty);
        logic [2:0] used;
        used = 3'(3'd4 - empty);
        return 8'd8 - 8'(used);
    endfunction

endpackage

/* hw/axis_tx_capture.sv */
// stream input capture, masks unused lanes and holds the current data word
module axis_tx_capture (
    input  logic                               clk,
    input  logic                               reset_crc,
    input  logic [xgmii_tx_pkg::DATA_W-1:0]    s_tdata,
    input  logic [xgmii_tx_pkg::LANES-1:0]     s_tkeep,
    input  logic                               load,
    input  logic                               zero_fill,
    output logic [xgmii_tx_pkg::DATA_W-1:0]    hold_data,
    output logic [xgmii_tx_pkg::EMPTY_W-1:0]   beat_empty
);

    logic [xgmii_tx_pkg::DATA_W-1:0] masked;

    always_comb begin
        for (int n = 0; n < xgmii_tx_pkg::LANES; n++) begin
            // lane 0 always carries a byte
            if (n == 0 || s_tkeep[n]) begin
                masked[8*n +: 8] = s_tdata[8*n +: 8];
            end else begin
                masked[8*n +: 8] = 8'd0;
            end
        end
    end

    assign beat_empty = xgmii_tx_pkg::keep_to_empty(s_tkeep);

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            hold_data <= '0;
        end else if (zero_fill) begin
            hold_data <= '0;
        end else if (load) begin
            hold_data <= masked;
        end
    end

endmodule

/* hw/eth_fcs_crc.sv */
// running crc-32 with parallel results for one to eight low bytes
module eth_fcs_crc (
    input  logic                                  clk,
    input  logic                                  reset_crc,
    input  logic [xgmii_tx_pkg::DATA_W-1:0]       data,
    input  logic                                  crc_init,
    input  logic                                  crc_update,
    output logic [xgmii_tx_pkg::LANES-1:0][31:0]  crc_lane,
    output logic [31:0]                           crc_reg
);

    localparam logic [31:0] POLY_R = {<<{xgmii_tx_pkg::CRC_POLY}};

    logic [xgmii_tx_pkg::LANES-1:0][31:0] part;

    // reflected galois step over one byte, lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] d);
        logic [31:0] c;
        c = crc;
        for (int b = 0; b < 8; b++) begin
            c = (c >> 1) ^ (POLY_R & {32{c[0] ^ d[b]}});
        end
        return c;
    endfunction

    always_comb begin
        logic [31:0] c;
        c = crc_reg;
        for (int n = 0; n < xgmii_tx_pkg::LANES; n++) begin
            c = crc_byte(c, data[8*n +: 8]);
            part[n] = c;
        end
    end

    // partial results stay put after the last update for the fcs split
    always_ff @(posedge clk) begin
        if (crc_update) begin
            crc_lane <= part;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc || crc_init) begin
            crc_reg <= '1;
        end else if (crc_update) begin
            crc_reg <= part[xgmii_tx_pkg::LANES-1];
        end
    end

    a_init_update_excl: assert property (@(posedge clk) disable iff (reset_crc)
        !(crc_init && crc_update));

endmodule

/* hw/tx_frame_ctrl.sv */
// transmit frame fsm with ready, minimum length padding and inter-frame gap
module tx_frame_ctrl #(
    parameter int MIN_FRAME_LEN = 64,
    parameter bit PADDING_EN = 1'b1
) (
    input  logic                               clk,
    input  logic                               reset_crc,
    input  logic                               s_tvalid,
    input  logic                               s_tlast,
    input  logic                               s_tuser,
    input  logic [xgmii_tx_pkg::EMPTY_W-1:0]   beat_empty,
    input  logic [7:0]                         cfg_tx_ifg,
    input  logic                               cfg_tx_enable,
    output logic                               s_tready,
    output logic                               load,
    output logic                               zero_fill,
    output logic                               crc_init,
    output logic                               crc_update,
    output xgmii_tx_pkg::tx_state_e            state,
    output logic [xgmii_tx_pkg::EMPTY_W-1:0]   hold_empty
);

    localparam int NEED_W = $clog2(MIN_FRAME_LEN + 1);
    // bytes needed before the fcs, first beat included
    localparam logic [NEED_W-1:0] FIRST_NEED = NEED_W'(MIN_FRAME_LEN - 4);
    localparam logic [NEED_W-1:0] LANE_BYTES = NEED_W'(xgmii_tx_pkg::LANES);

    xgmii_tx_pkg::tx_state_e state_next;
    logic tready_next;
    logic frame_reg, frame_next;
    logic err_reg, err_next;
    logic [NEED_W-1:0] need_reg, need_next, need_now;
    logic [7:0] ifg_cnt, ifg_next, gap_max;
    logic [xgmii_tx_pkg::EMPTY_W-1:0] empty_next, padded_empty;
    logic accept, pad_more;

    assign accept = s_tvalid && s_tready;
    assign need_now = (state == xgmii_tx_pkg::IDLE) ? FIRST_NEED : need_reg;
    assign pad_more = PADDING_EN && (need_now > LANE_BYTES);
    assign gap_max = (cfg_tx_ifg > xgmii_tx_pkg::MIN_IFG_BYTES) ? cfg_tx_ifg
                                                               : xgmii_tx_pkg::MIN_IFG_BYTES;

    assign load = accept && (state == xgmii_tx_pkg::IDLE || state == xgmii_tx_pkg::PAYLOAD);
    assign zero_fill = (state == xgmii_tx_pkg::PAD);
    assign crc_init = (state == xgmii_tx_pkg::IDLE);
    assign crc_update = (state == xgmii_tx_pkg::PAYLOAD) || (state == xgmii_tx_pkg::PAD) ||
                        (state == xgmii_tx_pkg::FCS_1);

    // a short last beat is stretched to cover the minimum length
    always_comb begin
        padded_empty = beat_empty;
        if (PADDING_EN && need_now != 0) begin
            if (need_now > LANE_BYTES) begin
                padded_empty = '0;
            end else if (beat_empty > 3'(LANE_BYTES - need_now)) begin
                padded_empty = 3'(LANE_BYTES - need_now);
            end
        end
    end

    always_comb begin
        state_next = state;
        tready_next = 1'b0;
        frame_next = accept ? !s_tlast : frame_reg;
        err_next = err_reg;
        need_next = need_reg;
        ifg_next = ifg_cnt;
        empty_next = hold_empty;

        if ((state == xgmii_tx_pkg::IDLE && accept) || state == xgmii_tx_pkg::PAYLOAD) begin
            empty_next = padded_empty;
            need_next = pad_more ? need_now - LANE_BYTES : '0;
        end

        case (state)
            xgmii_tx_pkg::IDLE: begin
                err_next = 1'b0;
                tready_next = cfg_tx_enable;
                if (accept) begin
                    tready_next = 1'b1;
                    state_next = xgmii_tx_pkg::PAYLOAD;
                    if (s_tlast) begin
                        tready_next = 1'b0;
                        err_next = s_tuser;
                        state_next = pad_more ? xgmii_tx_pkg::PAD :
                                     s_tuser ? xgmii_tx_pkg::ERR : xgmii_tx_pkg::FCS_1;
                    end
                end
            end
            xgmii_tx_pkg::PAYLOAD: begin
                tready_next = 1'b1;
                // low valid here is an underflow
                if (!s_tvalid || s_tlast) begin
                    tready_next = frame_next;
                    err_next = !s_tvalid || s_tuser;
                    state_next = pad_more ? xgmii_tx_pkg::PAD :
                                 err_next ? xgmii_tx_pkg::ERR : xgmii_tx_pkg::FCS_1;
                end
            end
            xgmii_tx_pkg::PAD: begin
                tready_next = frame_next;
                if (need_reg > LANE_BYTES) begin
                    need_next = need_reg - LANE_BYTES;
                end else begin
                    empty_next = 3'(LANE_BYTES - need_reg);
                    need_next = '0;
                    state_next = err_reg ? xgmii_tx_pkg::ERR : xgmii_tx_pkg::FCS_1;
                end
            end
            xgmii_tx_pkg::FCS_1: begin
                tready_next = frame_next;
                ifg_next = gap_max - xgmii_tx_pkg::term_ifg_offset(hold_empty);
                state_next = (hold_empty <= 3'd4) ? xgmii_tx_pkg::FCS_2 : xgmii_tx_pkg::IFG;
            end
            xgmii_tx_pkg::FCS_2: begin
                tready_next = frame_next;
                state_next = xgmii_tx_pkg::IFG;
            end
            xgmii_tx_pkg::ERR: begin
                tready_next = frame_next;
                ifg_next = gap_max;
                state_next = xgmii_tx_pkg::IFG;
            end
            xgmii_tx_pkg::IFG: begin
                ifg_next = (ifg_cnt > 8'd8) ? ifg_cnt - 8'd8 : 8'd0;
                if (ifg_next != 0 || frame_reg) begin
                    tready_next = frame_next;
                end else begin
                    tready_next = cfg_tx_enable;
                    state_next = xgmii_tx_pkg::IDLE;
                end
            end
            default: state_next = xgmii_tx_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state <= xgmii_tx_pkg::IDLE;
            s_tready <= 1'b0;
            frame_reg <= 1'b0;
            err_reg <= 1'b0;
            need_reg <= '0;
            ifg_cnt <= '0;
            hold_empty <= '0;
        end else begin
            state <= state_next;
            s_tready <= tready_next;
            frame_reg <= frame_next;
            err_reg <= err_next;
            need_reg <= need_next;
            ifg_cnt <= ifg_next;
            hold_empty <= empty_next;
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (reset_crc)
        state inside {xgmii_tx_pkg::IDLE, xgmii_tx_pkg::PAYLOAD, xgmii_tx_pkg::PAD,
                      xgmii_tx_pkg::FCS_1, xgmii_tx_pkg::FCS_2, xgmii_tx_pkg::ERR,
                      xgmii_tx_pkg::IFG});

    a_err_drop_only: assert property (@(posedge clk) disable iff (reset_crc)
        (state == xgmii_tx_pkg::ERR && s_tready) |-> frame_reg);

endmodule

/* hw/xgmii_lane_encoder.sv */
// xgmii lane encoder for start, payload, fcs, terminate, error and idle words
module xgmii_lane_encoder (
    input  logic                                  clk,
    input  logic                                  reset_crc,
    input  xgmii_tx_pkg::tx_state_e               state,
    input  logic [xgmii_tx_pkg::DATA_W-1:0]       hold_data,
    input  logic [xgmii_tx_pkg::EMPTY_W-1:0]      hold_empty,
    input  logic [xgmii_tx_pkg::LANES-1:0][31:0]  crc_lane,
    input  logic [31:0]                           crc_reg,
    output logic [xgmii_tx_pkg::DATA_W-1:0]       xgmii_txd,
    output logic [xgmii_tx_pkg::LANES-1:0]        xgmii_txc
);

    xgmii_tx_pkg::tx_state_e state_q;
    logic [xgmii_tx_pkg::DATA_W-1:0] data_q;
    logic [xgmii_tx_pkg::EMPTY_W-1:0] empty_q;
    logic [2*xgmii_tx_pkg::DATA_W-1:0] seq_d;
    logic [2*xgmii_tx_pkg::LANES-1:0] seq_c;
    logic [xgmii_tx_pkg::DATA_W-1:0] txd_next;
    logic [xgmii_tx_pkg::LANES-1:0] txc_next;
    logic [31:0] fcs;
    logic start_now;
    int nd;

    // a one-beat frame leaves idle straight for pad or error
    assign start_now = (state != xgmii_tx_pkg::IDLE) && (state_q == xgmii_tx_pkg::IDLE);

    // data bytes, fcs, terminate, idles laid over two words
    always_comb begin
        nd = xgmii_tx_pkg::LANES - int'(empty_q);
        fcs = ~((empty_q == 0) ? crc_reg : crc_lane[3'(3'd7 - empty_q)]);
        seq_d = {(2*xgmii_tx_pkg::LANES){xgmii_tx_pkg::XGMII_IDLE}};
        seq_c = '1;
        for (int i = 0; i < xgmii_tx_pkg::LANES; i++) begin
            if (i < nd) begin
                seq_d[8*i +: 8] = data_q[8*i +: 8];
                seq_c[i] = 1'b0;
            end
        end
        for (int j = 0; j < 4; j++) begin
            seq_d[8*(nd+j) +: 8] = fcs[8*j +: 8];
            seq_c[nd+j] = 1'b0;
        end
        seq_d[8*(nd+4) +: 8] = xgmii_tx_pkg::XGMII_TERM;
    end

    always_comb begin
        txd_next = {xgmii_tx_pkg::LANES{xgmii_tx_pkg::XGMII_IDLE}};
        txc_next = '1;
        case (state_q)
            xgmii_tx_pkg::PAYLOAD, xgmii_tx_pkg::PAD: begin
                txd_next = data_q;
                txc_next = '0;
            end
            xgmii_tx_pkg::FCS_1: begin
                txd_next = seq_d[xgmii_tx_pkg::DATA_W-1:0];
                txc_next = seq_c[xgmii_tx_pkg::LANES-1:0];
            end
            xgmii_tx_pkg::FCS_2: begin
                txd_next = seq_d[2*xgmii_tx_pkg::DATA_W-1:xgmii_tx_pkg::DATA_W];
                txc_next = seq_c[2*xgmii_tx_pkg::LANES-1:xgmii_tx_pkg::LANES];
            end
            xgmii_tx_pkg::ERR: begin
                txd_next = {xgmii_tx_pkg::XGMII_TERM, {7{xgmii_tx_pkg::XGMII_ERROR}}};
            end
            default: ;
        endcase
        if (start_now) begin
            txd_next = {xgmii_tx_pkg::ETH_SFD, {6{xgmii_tx_pkg::ETH_PRE}},
                        xgmii_tx_pkg::XGMII_START};
            txc_next = 8'h01;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state_q <= xgmii_tx_pkg::IDLE;
            xgmii_txd <= {xgmii_tx_pkg::LANES{xgmii_tx_pkg::XGMII_IDLE}};
            xgmii_txc <= '1;
        end else begin
            state_q <= state;
            xgmii_txd <= txd_next;
            xgmii_txc <= txc_next;
        end
    end

    // one word of lag so the start word fits ahead of beat 0
    always_ff @(posedge clk) begin
        data_q <= hold_data;
        empty_q <= hold_empty;
    end

    a_start_ctrl: assert property (@(posedge clk) disable iff (reset_crc)
        (xgmii_txc[0] && xgmii_txd[7:0] == xgmii_tx_pkg::XGMII_START) |-> xgmii_txc == 8'h01);

endmodule

/* hw/xgmii_tx_top.sv */
// 64-bit ethernet transmitter, byte stream in and xgmii out
module xgmii_tx_top #(
    parameter int MIN_FRAME_LEN = 64,
    parameter bit PADDING_EN = 1'b1
) (
    input  logic                               clk,
    input  logic                               reset_crc,
    input  logic [xgmii_tx_pkg::DATA_W-1:0]    s_tdata,
    input  logic [xgmii_tx_pkg::LANES-1:0]     s_tkeep,
    input  logic                               s_tvalid,
    input  logic                               s_tlast,
    input  logic                               s_tuser,
    output logic                               s_tready,
    input  logic [7:0]                         cfg_tx_ifg,
    input  logic                               cfg_tx_enable,
    output logic [xgmii_tx_pkg::DATA_W-1:0]    xgmii_txd,
    output logic [xgmii_tx_pkg::LANES-1:0]     xgmii_txc
);

    logic [xgmii_tx_pkg::DATA_W-1:0] hold_data;
    logic [xgmii_tx_pkg::EMPTY_W-1:0] beat_empty;
    logic [xgmii_tx_pkg::EMPTY_W-1:0] hold_empty;
    logic load;
    logic zero_fill;
    logic crc_init;
    logic crc_update;
    xgmii_tx_pkg::tx_state_e state;
    logic [xgmii_tx_pkg::LANES-1:0][31:0] crc_lane;
    logic [31:0] crc_reg;

    axis_tx_capture u_capture (
        .clk(clk),
        .reset_crc(reset_crc),
        .s_tdata(s_tdata),
        .s_tkeep(s_tkeep),
        .load(load),
        .zero_fill(zero_fill),
        .hold_data(hold_data),
        .beat_empty(beat_empty)
    );

    tx_frame_ctrl #(
        .MIN_FRAME_LEN(MIN_FRAME_LEN),
        .PADDING_EN(PADDING_EN)
    ) u_ctrl (
        .clk(clk),
        .reset_crc(reset_crc),
        .s_tvalid(s_tvalid),
        .s_tlast(s_tlast),
        .s_tuser(s_tuser),
        .beat_empty(beat_empty),
        .cfg_tx_ifg(cfg_tx_ifg),
        .cfg_tx_enable(cfg_tx_enable),
        .s_tready(s_tready),
        .load(load),
        .zero_fill(zero_fill),
        .crc_init(crc_init),
        .crc_update(crc_update),
        .state(state),
        .hold_empty(hold_empty)
    );

    eth_fcs_crc u_crc (
        .clk(clk),
        .reset_crc(reset_crc),
        .data(hold_data),
        .crc_init(crc_init),
        .crc_update(crc_update),
        .crc_lane(crc_lane),
        .crc_reg(crc_reg)
    );

    xgmii_lane_encoder u_encoder (
        .clk(clk),
        .reset_crc(reset_crc),
        .state(state),
        .hold_data(hold_data),
        .hold_empty(hold_empty),
        .crc_lane(crc_lane),
        .crc_reg(crc_reg),
        .xgmii_txd(xgmii_txd),
        .xgmii_txc(xgmii_txc)
    );

endmodule

/* sim/tb_xgmii_tx.sv */
// testbench for the xgmii transmitter, random frames checked against a byte-level frame model
module tb_xgmii_tx;
    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [7:0] byte_q_t[$];

    localparam int TOTAL_FRAMES = 45;
    localparam int CYCLES_PER_FRAME = 200;

    logic clk;
    logic reset_crc;
    logic [63:0] s_tdata;
    logic [7:0] s_tkeep;
    logic s_tvalid;
    logic s_tlast;
    logic s_tuser;
    logic s_tready;
    logic [7:0] cfg_tx_ifg;
    logic cfg_tx_enable;
    logic [63:0] xgmii_txd;
    logic [7:0] xgmii_txc;

    // expected wire bytes of good frames, back to back
    logic [7:0] exp_bytes[$];
    int exp_len[$];
    bit exp_err[$];
    int frames_sent;
    int frames_seen;
    int starts_seen;

    bit in_frame;
    bit have_gap;
    int gap_bytes;
    int gap_need;
    logic [7:0] rx_bytes[$];

    xgmii_tx_top #(
        .MIN_FRAME_LEN(64),
        .PADDING_EN(1'b1)
    ) dut_i (
        .clk(clk),
        .reset_crc(reset_crc),
        .s_tdata(s_tdata),
        .s_tkeep(s_tkeep),
        .s_tvalid(s_tvalid),
        .s_tlast(s_tlast),
        .s_tuser(s_tuser),
        .s_tready(s_tready),
        .cfg_tx_ifg(cfg_tx_ifg),
        .cfg_tx_enable(cfg_tx_enable),
        .xgmii_txd(xgmii_txd),
        .xgmii_txc(xgmii_txc)
    );

    always #10 clk = ~clk;

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            stop_on_error($sformatf("[FAIL] time %0t %s got 0x%0h expected 0x%0h",
                                    $time, name, got, want));
        end
    endtask

    // reflected crc-32, final value inverted
    function automatic logic [31:0] crc32_bytes(input byte_q_t data);
        logic [31:0] c;
        c = 32'hFFFF_FFFF;
        foreach (data[i]) begin
            c = c ^ {24'd0, data[i]};
            for (int b = 0; b < 8; b++) begin
                if (c[0]) begin
                    c = (c >> 1) ^ 32'hEDB8_8320;
                end else begin
                    c = c >> 1;
                end
            end
        end
        return ~c;
    endfunction

    // preamble, sfd, payload padded to 60 bytes, fcs low byte first
    function automatic byte_q_t wire_frame(input byte_q_t payload);
        byte_q_t w;
        byte_q_t body;
        logic [31:0] fcs;
        body = payload;
        while (body.size() < 60) begin
            body.push_back(8'h00);
        end
        fcs = crc32_bytes(body);
        for (int i = 0; i < 6; i++) begin
            w.push_back(8'h55);
        end
        w.push_back(8'hD5);
        foreach (body[i]) begin
            w.push_back(body[i]);
        end
        for (int j = 0; j < 4; j++) begin
            w.push_back(fcs[8*j +: 8]);
        end
        return w;
    endfunction

    task automatic drive_beat(input logic [63:0] data, input logic [7:0] keep,
                              input logic last, input logic user);
        s_tdata = data;
        s_tkeep = keep;
        s_tvalid = 1'b1;
        s_tlast = last;
        s_tuser = user;
        while (!s_tready) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    // kind 0 good, 1 user error on the last beat, 2 valid dropped before beat 2
    task automatic send_frame(input int len, input int kind);
        byte_q_t payload;
        byte_q_t w;
        int nbeats;
        int n;
        logic [63:0] data;
        logic [7:0] keep;
        for (int i = 0; i < len; i++) begin
            payload.push_back(8'($urandom));
        end
        nbeats = (len + 7) / 8;
        if (kind == 0) begin
            w = wire_frame(payload);
            foreach (w[i]) begin
                exp_bytes.push_back(w[i]);
            end
            exp_len.push_back(w.size());
        end else begin
            exp_len.push_back(0);
        end
        exp_err.push_back(kind != 0);
        frames_sent++;
        for (int b = 0; b < nbeats; b++) begin
            if (kind == 2 && b == 2) begin
                s_tvalid = 1'b0;
                repeat (1 + $urandom_range(2)) @(negedge clk);
            end
            n = (b == nbeats - 1) ? len - 8 * b : 8;
            // junk in the unused lanes
            data = {$urandom, $urandom};
            keep = 8'hFF >> (8 - n);
            for (int k = 0; k < n; k++) begin
                data[8*k +: 8] = payload[8*b + k];
            end
            drive_beat(data, keep, b == nbeats - 1, kind == 1 && b == nbeats - 1);
        end
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        s_tuser = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_quiet();
        while (frames_seen != frames_sent) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic end_frame(input bit was_err);
        bit want_err;
        int want_len;
        logic [7:0] want_byte;
        if (exp_err.size() == 0) begin
            stop_on_error("a frame appeared on xgmii that was never sent");
        end else begin
            want_err = exp_err.pop_front();
            want_len = exp_len.pop_front();
            check_value("frame error flag", 64'(was_err), 64'(want_err));
            if (!want_err) begin
                check_value("frame length", 64'(rx_bytes.size()), 64'(want_len));
                foreach (rx_bytes[i]) begin
                    want_byte = exp_bytes.pop_front();
                    check_value($sformatf("xgmii_txd byte %0d", i), rx_bytes[i], want_byte);
                end
            end
            in_frame = 1'b0;
            have_gap = 1'b1;
            gap_need = (cfg_tx_ifg > 8'd12) ? int'(cfg_tx_ifg) : 12;
            frames_seen++;
        end
    endtask

    // terminate counts as the first byte of the gap
    task automatic take_word(input logic [63:0] d, input logic [7:0] c);
        int term_at;
        if (!in_frame) begin
            if (c == 8'h01 && d[7:0] == xgmii_tx_pkg::XGMII_START) begin
                if (have_gap && gap_bytes < gap_need) begin
                    stop_on_error($sformatf("gap of %0d bytes before start at %0t, need %0d",
                                            gap_bytes, $time, gap_need));
                end
                starts_seen++;
                in_frame = 1'b1;
                rx_bytes.delete();
                for (int i = 1; i < 8; i++) begin
                    rx_bytes.push_back(d[8*i +: 8]);
                end
            end else begin
                check_value("xgmii_txc", c, 64'hFF);
                check_value("xgmii_txd", d, {8{xgmii_tx_pkg::XGMII_IDLE}});
                gap_bytes += 8;
            end
        end else if (c == 8'h00) begin
            for (int i = 0; i < 8; i++) begin
                rx_bytes.push_back(d[8*i +: 8]);
            end
        end else if (c[0] && d[7:0] == xgmii_tx_pkg::XGMII_ERROR) begin
            check_value("xgmii_txc", c, 64'hFF);
            check_value("xgmii_txd", d, {xgmii_tx_pkg::XGMII_TERM, {7{xgmii_tx_pkg::XGMII_ERROR}}});
            end_frame(1'b1);
            gap_bytes = 1;
        end else begin
            term_at = -1;
            for (int i = 0; i < 8; i++) begin
                if (term_at < 0) begin
                    if (c[i]) begin
                        term_at = i;
                        check_value("xgmii_txd terminate lane", d[8*i +: 8],
                                    xgmii_tx_pkg::XGMII_TERM);
                    end else begin
                        rx_bytes.push_back(d[8*i +: 8]);
                    end
                end else begin
                    check_value("xgmii_txc after terminate", 64'(c[i]), 64'd1);
                    check_value("xgmii_txd after terminate", d[8*i +: 8],
                                xgmii_tx_pkg::XGMII_IDLE);
                end
            end
            end_frame(1'b0);
            gap_bytes = 8 - term_at;
        end
    endtask

    always @(negedge clk) begin
        if (reset_crc) begin
            in_frame = 1'b0;
            have_gap = 1'b0;
            gap_bytes = 0;
        end else begin
            take_word(xgmii_txd, xgmii_txc);
        end
    end

    initial begin
        repeat (CYCLES_PER_FRAME * TOTAL_FRAMES) @(posedge clk);
        stop_on_error($sformatf("watchdog expired with %0d of %0d frames seen on xgmii",
                                frames_seen, frames_sent));
    end

    initial begin
        int seed_val;
        int starts_before;
        int ifg;
        byte_q_t ascii;
        seed_val = $urandom(83900);
        clk = 1'b0;
        reset_crc = 1'b1;
        s_tdata = '0;
        s_tkeep = '0;
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        s_tuser = 1'b0;
        cfg_tx_ifg = 8'd12;
        cfg_tx_enable = 1'b1;
        frames_sent = 0;
        frames_seen = 0;
        starts_seen = 0;

        // model sanity on the usual check string
        for (int i = 0; i < 9; i++) begin
            ascii.push_back(8'h31 + 8'(i));
        end
        check_value("reference crc", 64'(crc32_bytes(ascii)), 64'hCBF4_3926);

        repeat (8) begin
            @(negedge clk);
            check_value("s_tready", 64'(s_tready), 64'd0);
        end
        reset_crc = 1'b0;
        @(negedge clk);
        check_value("xgmii_txc", xgmii_txc, 64'hFF);
        check_value("xgmii_txd", xgmii_txd, {8{xgmii_tx_pkg::XGMII_IDLE}});

        for (int f = 0; f < 12; f++) begin
            send_frame(60 + $urandom_range(240), 0);
        end
        // short frames get padded
        for (int f = 0; f < 8; f++) begin
            idle_cycles($urandom_range(3));
            send_frame(1 + $urandom_range(58), 0);
        end
        for (int f = 0; f < 6; f++) begin
            if (f < 3) begin
                send_frame(1 + $urandom_range(199), 1);
            end else begin
                send_frame(24 + $urandom_range(176), 2);
            end
            idle_cycles($urandom_range(3));
            send_frame(40 + $urandom_range(80), 0);
        end
        for (int g = 0; g < 3; g++) begin
            ifg = (g == 0) ? 8 : (g == 1) ? 12 : 20;
            wait_quiet();
            cfg_tx_ifg = 8'(ifg);
            for (int f = 0; f < 4; f++) begin
                send_frame(8 + $urandom_range(120), 0);
            end
        end

        // disabled transmitter holds a waiting frame
        wait_quiet();
        cfg_tx_enable = 1'b0;
        idle_cycles(8);
        starts_before = starts_seen;
        fork
            send_frame(30 + $urandom_range(60), 0);
            begin
                repeat (30) begin
                    @(negedge clk);
                    check_value("s_tready", 64'(s_tready), 64'd0);
                end
                check_value("start words while disabled", 64'(starts_seen), 64'(starts_before));
                cfg_tx_enable = 1'b1;
            end
        join

        wait_quiet();
        idle_cycles(20);
        if (exp_err.size() == 0 && exp_bytes.size() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            stop_on_error("expected frames never appeared on xgmii");
        end
    end

endmodule

/* list.f */
hw/xgmii_tx_pkg.sv
hw/axis_tx_capture.sv
hw/eth_fcs_crc.sv
hw/tx_frame_ctrl.sv
hw/xgmii_lane_encoder.sv
hw/xgmii_tx_top.sv
sim/tb_xgmii_tx.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_xgmii_tx -f list.f -o tb_xgmii_tx

./obj_dir/tb_xgmii_tx | tee sim.log

if grep -qx "test passed" sim.log; then
    echo "simulation ok"
    exit 0
else
    echo "simulation reported failure"
    exit 1
fi
